/* include/radarDefines.svh */
`ifndef RADAR_DEFINES_SVH
`define RADAR_DEFINES_SVH

// SPI timing
`define SPI_CLKS_PER_HALF_BIT 3
`define SPI_CS_INACTIVE_CLKS  10

// LMX register words
`define LMX_WORD_BITS    24
`define LMX_TX_N_ADDR    8'h24
`define LMX_LO1_N_ADDR   8'h24
`define LMX_TX_N_BASE    16'd100
`define LMX_IF_N_OFFSET  16'd2    // LO1 sits above TX
`define LMX_N_STEP       16'd1
`define LMX_VCO_CAL_WORD 24'h00201C

// UART and frame
`define UART_CLKS_PER_BIT 868     // 115200 baud at 100 MHz
`define FRAME_HEADER_BYTE 8'hCC
`define FRAME_MARKER_A    8'h55
`define FRAME_MARKER_B    8'h11
`define FRAME_STOP_BYTE   8'h99
`define FRAME_MARK_COUNT  3

`define SWEEP_POINTS_DEFAULT 200
`define DWELL_CYCLES_DEFAULT 80000

`endif

/* hdl/radarPkg.sv */
`include "radarDefines.svh"

package radarPkg;

    typedef logic [`LMX_WORD_BITS-1:0] lmxWord_t;

    typedef enum logic [1:0] {
        TGT_TX,
        TGT_LO1,
        TGT_BOTH
    } lmxTarget_t;

    typedef enum logic [2:0] {
        WRITE_TX,
        WRITE_LO1,
        WRITE_CAL,
        DWELL,
        WAIT_FRAME
    } seqState_t;

    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        MARKER,
        DATA,
        STOP,
        DRAIN
    } frameState_t;

    typedef logic signed [47:0] iqSample_t;

    typedef enum logic [1:0] {
        I_TX,
        Q_TX,
        I_RX,
        Q_RX
    } iqComp_t;

endpackage

/* hdl/spiWordIf.sv */
`timescale 1ns/1ps

interface spiWordIf import radarPkg::*; ();

    lmxWord_t   word;
    lmxTarget_t target;
    logic       start;   // One-cycle pulse
    logic       busy;
    logic       done;    // One-cycle pulse after CS rises

    modport writer (
        input  word, target, start,
        output busy, done
    );

    modport requester (
        output word, target, start,
        input  busy, done
    );

endinterface

/* hdl/lmxSpiWriter.sv */
`timescale 1ns/1ps
`include "radarDefines.svh"

module lmxSpiWriter import radarPkg::*; (
    input  logic     i_clk,
    input  logic     i_resetN,
    spiWordIf.writer bus,
    output logic     o_spiClk,
    output logic     o_spiMosi,
    output logic     o_spiCsTx_n,
    output logic     o_spiCsLo1_n
);

    localparam int HalfW = $clog2(`SPI_CLKS_PER_HALF_BIT + 1);
    localparam int BitW  = $clog2(`LMX_WORD_BITS);
    localparam int GapW  = $clog2(`SPI_CS_INACTIVE_CLKS + 1);

    lmxWord_t         shiftReg;
    lmxTarget_t       targetReg;
    logic [HalfW-1:0] halfCnt;
    logic [BitW-1:0]  bitCnt;
    logic [GapW-1:0]  gapCnt;
    logic             csActive;
    logic             inGap;
    logic             accept;
    logic             halfDone;

    assign accept   = bus.start && !bus.busy;
    assign halfDone = (halfCnt == HalfW'(`SPI_CLKS_PER_HALF_BIT - 1));

    assign o_spiMosi    = shiftReg[`LMX_WORD_BITS-1];   // MSB first
    assign o_spiCsTx_n  = !(csActive && targetReg != TGT_LO1);
    assign o_spiCsLo1_n = !(csActive && targetReg != TGT_TX);

    always_ff @(posedge i_clk) begin
        if (accept) begin
            shiftReg  <= bus.word;
            targetReg <= bus.target;
        end else if (csActive && halfDone && o_spiClk) begin
            shiftReg <= {shiftReg[`LMX_WORD_BITS-2:0], 1'b0};   // Change on falling SCLK
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_resetN) begin
            csActive <= 1'b0;
            inGap    <= 1'b0;
            o_spiClk <= 1'b0;
            halfCnt  <= '0;
            bitCnt   <= '0;
            gapCnt   <= '0;
            bus.busy <= 1'b0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (accept) begin
                bus.busy <= 1'b1;
                csActive <= 1'b1;
                halfCnt  <= '0;
                bitCnt   <= '0;
            end else if (csActive) begin
                if (halfDone) begin
                    halfCnt  <= '0;
                    o_spiClk <= !o_spiClk;
                    if (o_spiClk) begin
                        if (bitCnt == BitW'(`LMX_WORD_BITS - 1)) begin
                            csActive <= 1'b0;
                            inGap    <= 1'b1;
                            gapCnt   <= '0;
                            bus.done <= 1'b1;
                        end else begin
                            bitCnt <= bitCnt + 1'b1;
                        end
                    end
                end else begin
                    halfCnt <= halfCnt + 1'b1;
                end
            end else if (inGap) begin
                gapCnt <= gapCnt + 1'b1;
                if (gapCnt == GapW'(`SPI_CS_INACTIVE_CLKS - 1)) begin
                    inGap    <= 1'b0;
                    bus.busy <= 1'b0;
                end
            end
        end
    end

    csOnlyWhenBusy: assert property (@(posedge i_clk) disable iff (!i_resetN)
        (!o_spiCsTx_n || !o_spiCsLo1_n) |-> bus.busy)
        else $error("chip select low while writer idle");

    noStartWhenBusy: assert property (@(posedge i_clk) disable iff (!i_resetN)
        bus.start |-> !bus.busy)
        else $error("SPI start while writer busy");

endmodule

/* hdl/sweepSequencer.sv */
`timescale 1ns/1ps
`include "radarDefines.svh"

module sweepSequencer import radarPkg::*; #(
    parameter  int NumPoints   = `SWEEP_POINTS_DEFAULT,
    parameter  int DwellCycles = `DWELL_CYCLES_DEFAULT,
    localparam int IdxW        = (NumPoints > 1) ? $clog2(NumPoints) : 1
) (
    input  logic            i_clk,
    input  logic            i_resetN,
    spiWordIf.requester     spi,
    output logic            o_spiCe,
    output logic            o_capture,
    output logic [IdxW-1:0] o_captureIndex,
    input  logic            i_frameBusy,
    output logic            o_frameStart
);

    localparam int DwellW = $clog2(DwellCycles + 1);

    seqState_t         state;
    logic [IdxW-1:0]   stepIndex;
    logic [DwellW-1:0] dwellCnt;
    logic [15:0]       txDivider;
    logic              issued;    // Start given for this word
    logic              gotDone;
    logic              startPulse;

    assign txDivider      = `LMX_TX_N_BASE + 16'(stepIndex) * `LMX_N_STEP;
    assign spi.start      = startPulse;
    assign o_captureIndex = stepIndex;

    always_comb begin
        case (state)
            WRITE_TX: begin
                spi.word   = {`LMX_TX_N_ADDR, txDivider};
                spi.target = TGT_TX;
            end
            WRITE_LO1: begin
                spi.word   = {`LMX_LO1_N_ADDR, txDivider + `LMX_IF_N_OFFSET};
                spi.target = TGT_LO1;
            end
            default: begin
                spi.word   = `LMX_VCO_CAL_WORD;
                spi.target = TGT_BOTH;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Sweep FSM
    //////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (!i_resetN) begin
            state        <= WRITE_TX;
            stepIndex    <= '0;
            dwellCnt     <= '0;
            issued       <= 1'b0;
            gotDone      <= 1'b0;
            startPulse   <= 1'b0;
            o_spiCe      <= 1'b0;
            o_capture    <= 1'b0;
            o_frameStart <= 1'b0;
        end else begin
            o_spiCe      <= 1'b1;
            startPulse   <= 1'b0;
            o_capture    <= 1'b0;
            o_frameStart <= 1'b0;
            case (state)
                WRITE_TX, WRITE_LO1, WRITE_CAL: begin
                    if (!issued && !spi.busy && o_spiCe) begin
                        startPulse <= 1'b1;
                        issued     <= 1'b1;
                    end
                    if (spi.done) begin
                        gotDone <= 1'b1;
                    end
                    if (gotDone && !spi.busy) begin
                        issued   <= 1'b0;
                        gotDone  <= 1'b0;
                        dwellCnt <= '0;
                        state    <= (state == WRITE_CAL) ? DWELL : seqState_t'(state + 1'b1);
                    end
                end
                DWELL: begin
                    dwellCnt <= dwellCnt + 1'b1;
                    if (dwellCnt == DwellW'(DwellCycles - 2)) begin
                        o_capture <= 1'b1;
                    end
                    if (o_capture) begin
                        if (stepIndex == IdxW'(NumPoints - 1)) begin
                            o_frameStart <= 1'b1;
                            state        <= WAIT_FRAME;
                        end else begin
                            stepIndex <= stepIndex + 1'b1;
                            state     <= WRITE_TX;
                        end
                    end
                end
                WAIT_FRAME: begin
                    if (!o_frameStart && !i_frameBusy) begin   // Frame fully sent
                        stepIndex <= '0;
                        state     <= WRITE_TX;
                    end
                end
                default: state <= WRITE_TX;
            endcase
        end
    end

    captureQuiet: assert property (@(posedge i_clk) disable iff (!i_resetN)
        o_capture |-> !spi.busy)
        else $error("capture while SPI busy");

endmodule

/* hdl/iqResultStore.sv */
`timescale 1ns/1ps
`include "radarDefines.svh"

module iqResultStore import radarPkg::*; #(
    parameter  int NumPoints = `SWEEP_POINTS_DEFAULT,
    localparam int IdxW      = (NumPoints > 1) ? $clog2(NumPoints) : 1
) (
    input  logic            i_clk,
    input  logic            i_capture,
    input  logic [IdxW-1:0] i_captureIndex,
    input  iqSample_t       i_iTx,
    input  iqSample_t       i_qTx,
    input  iqSample_t       i_iRx,
    input  iqSample_t       i_qRx,
    input  logic [IdxW-1:0] i_readIndex,
    input  iqComp_t         i_readComp,
    output iqSample_t       o_readData
);

    iqSample_t resultMem [4][NumPoints];   // One bank per component

    always_ff @(posedge i_clk) begin
        if (i_capture) begin
            resultMem[I_TX][i_captureIndex] <= i_iTx;
            resultMem[Q_TX][i_captureIndex] <= i_qTx;
            resultMem[I_RX][i_captureIndex] <= i_iRx;
            resultMem[Q_RX][i_captureIndex] <= i_qRx;
        end
        o_readData <= resultMem[i_readComp][i_readIndex];
    end

endmodule

/* hdl/uartFrameBuilder.sv */
`timescale 1ns/1ps
`include "radarDefines.svh"

module uartFrameBuilder import radarPkg::*; #(
    parameter  int NumPoints = `SWEEP_POINTS_DEFAULT,
    localparam int IdxW      = (NumPoints > 1) ? $clog2(NumPoints) : 1
) (
    input  logic            i_clk,
    input  logic            i_resetN,
    input  logic            i_frameStart,
    output logic            o_frameBusy,
    output logic [IdxW-1:0] o_readIndex,
    output iqComp_t         o_readComp,
    input  iqSample_t       i_readData,
    output logic [7:0]      o_txByte,
    output logic            o_txSend,
    input  logic            i_txBusy
);

    frameState_t state;
    logic [1:0]  markCnt;
    logic [1:0]  byteCnt;    // Byte within sample, MSB first
    logic [7:0]  dataByte;
    logic        txReady;

    assign txReady  = !i_txBusy && !o_txSend;
    assign dataByte = i_readData[6'd47 - {byteCnt, 3'b000} -: 8];   // Bits 47:16 only

    always_ff @(posedge i_clk) begin
        if (!i_resetN) begin
            state       <= IDLE;
            o_frameBusy <= 1'b0;
            o_txSend    <= 1'b0;
            markCnt     <= '0;
            byteCnt     <= '0;
            o_readIndex <= '0;
            o_readComp  <= I_TX;
        end else begin
            o_txSend <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_frameStart) begin
                        o_frameBusy <= 1'b1;
                        markCnt     <= '0;
                        byteCnt     <= '0;
                        o_readIndex <= '0;
                        o_readComp  <= I_TX;
                        state       <= HEADER;
                    end
                end
                HEADER: begin
                    if (txReady) begin
                        o_txSend <= 1'b1;
                        o_txByte <= `FRAME_HEADER_BYTE;
                        markCnt  <= markCnt + 1'b1;
                        if (markCnt == 2'(`FRAME_MARK_COUNT - 1)) begin
                            markCnt <= '0;
                            state   <= MARKER;
                        end
                    end
                end
                MARKER: begin   // 55 55 11 ahead of each point
                    if (txReady) begin
                        o_txSend <= 1'b1;
                        o_txByte <= (markCnt == 2'd2) ? `FRAME_MARKER_B : `FRAME_MARKER_A;
                        markCnt  <= markCnt + 1'b1;
                        if (markCnt == 2'd2) begin
                            markCnt <= '0;
                            state   <= DATA;
                        end
                    end
                end
                DATA: begin
                    if (txReady) begin
                        o_txSend <= 1'b1;
                        o_txByte <= dataByte;
                        byteCnt  <= byteCnt + 1'b1;
                        if (byteCnt == 2'd3) begin
                            o_readComp <= iqComp_t'(o_readComp + 1'b1);
                            if (o_readComp == Q_RX) begin
                                if (o_readIndex == IdxW'(NumPoints - 1)) begin
                                    state <= STOP;
                                end else begin
                                    o_readIndex <= o_readIndex + 1'b1;
                                    state       <= MARKER;
                                end
                            end
                        end
                    end
                end
                STOP: begin
                    if (txReady) begin
                        o_txSend <= 1'b1;
                        o_txByte <= `FRAME_STOP_BYTE;
                        markCnt  <= markCnt + 1'b1;
                        if (markCnt == 2'(`FRAME_MARK_COUNT - 1)) begin
                            state <= DRAIN;
                        end
                    end
                end
                DRAIN: begin
                    if (txReady) begin   // Last stop bit out
                        o_frameBusy <= 1'b0;
                        state       <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* hdl/uartTx.sv */
`timescale 1ns/1ps
`include "radarDefines.svh"

module uartTx (
    input  logic       i_clk,
    input  logic       i_resetN,
    input  logic [7:0] i_byte,
    input  logic       i_send,
    output logic       o_busy,
    output logic       o_serial
);

    localparam int ClkW = $clog2(`UART_CLKS_PER_BIT);

    logic [ClkW-1:0] clkCnt;
    logic [3:0]      bitCnt;    // Bits finished, start bit included
    logic [8:0]      dataReg;   // Stop bit on top

    always_ff @(posedge i_clk) begin
        if (!i_resetN) begin
            o_busy   <= 1'b0;
            o_serial <= 1'b1;   // Line idles high
            clkCnt   <= '0;
            bitCnt   <= '0;
        end else if (!o_busy) begin
            if (i_send) begin
                dataReg  <= {1'b1, i_byte};
                o_busy   <= 1'b1;
                o_serial <= 1'b0;
                clkCnt   <= '0;
                bitCnt   <= '0;
            end
        end else if (clkCnt == ClkW'(`UART_CLKS_PER_BIT - 1)) begin
            clkCnt <= '0;
            if (bitCnt == 4'd9) begin
                o_busy <= 1'b0;
            end else begin
                o_serial <= dataReg[bitCnt];   // LSB first
                bitCnt   <= bitCnt + 1'b1;
            end
        end else begin
            clkCnt <= clkCnt + 1'b1;
        end
    end

endmodule

/* hdl/radarTop.sv */
`timescale 1ns/1ps
`include "radarDefines.svh"

module radarTop import radarPkg::*; #(
    parameter  int NumPoints   = `SWEEP_POINTS_DEFAULT,
    parameter  int DwellCycles = `DWELL_CYCLES_DEFAULT,
    localparam int IdxW        = (NumPoints > 1) ? $clog2(NumPoints) : 1
) (
    input  logic      CLK100MHZ,
    input  logic      reset_reg,
    input  iqSample_t i_iTxAccum,
    input  iqSample_t i_qTxAccum,
    input  iqSample_t i_iRxAccum,
    input  iqSample_t i_qRxAccum,
    output logic      o_spiClk,
    output logic      o_spiMosi,
    output logic      o_spiCsTx_n,
    output logic      o_spiCsLo1_n,
    output logic      o_spiCe,
    output logic      o_uartTx
);

    logic            capture;
    logic [IdxW-1:0] captureIndex;
    logic            frameStart;
    logic            frameBusy;
    logic [IdxW-1:0] readIndex;
    iqComp_t         readComp;
    iqSample_t       readData;
    logic [7:0]      txByte;
    logic            txSend;
    logic            txBusy;

    spiWordIf spiBus ();

    //////////////////////////////////////////////////
    // Synthesizer control
    //////////////////////////////////////////////////
    lmxSpiWriter spiWriter0 (
        .i_clk        (CLK100MHZ),
        .i_resetN     (reset_reg),
        .bus          (spiBus.writer),
        .o_spiClk     (o_spiClk),
        .o_spiMosi    (o_spiMosi),
        .o_spiCsTx_n  (o_spiCsTx_n),
        .o_spiCsLo1_n (o_spiCsLo1_n)
    );

    sweepSequencer #(.NumPoints(NumPoints), .DwellCycles(DwellCycles)) sequencer0 (
        .i_clk          (CLK100MHZ),
        .i_resetN       (reset_reg),
        .spi            (spiBus.requester),
        .o_spiCe        (o_spiCe),
        .o_capture      (capture),
        .o_captureIndex (captureIndex),
        .i_frameBusy    (frameBusy),
        .o_frameStart   (frameStart)
    );

    //////////////////////////////////////////////////
    // Results and UART frame
    //////////////////////////////////////////////////
    iqResultStore #(.NumPoints(NumPoints)) store0 (
        .i_clk          (CLK100MHZ),
        .i_capture      (capture),
        .i_captureIndex (captureIndex),
        .i_iTx          (i_iTxAccum),
        .i_qTx          (i_qTxAccum),
        .i_iRx          (i_iRxAccum),
        .i_qRx          (i_qRxAccum),
        .i_readIndex    (readIndex),
        .i_readComp     (readComp),
        .o_readData     (readData)
    );

    uartFrameBuilder #(.NumPoints(NumPoints)) frameBuilder0 (
        .i_clk        (CLK100MHZ),
        .i_resetN     (reset_reg),
        .i_frameStart (frameStart),
        .o_frameBusy  (frameBusy),
        .o_readIndex  (readIndex),
        .o_readComp   (readComp),
        .i_readData   (readData),
        .o_txByte     (txByte),
        .o_txSend     (txSend),
        .i_txBusy     (txBusy)
    );

    uartTx uartTx0 (
        .i_clk    (CLK100MHZ),
        .i_resetN (reset_reg),
        .i_byte   (txByte),
        .i_send   (txSend),
        .o_busy   (txBusy),
        .o_serial (o_uartTx)
    );

endmodule

/* test/tbBusMonitor.sv */
`timescale 1ns/1ps
`include "radarDefines.svh"

module tbBusMonitor #(
    parameter int NumPoints = 4
) (
    input  logic        i_clk,
    input  logic        i_resetN,
    input  logic        i_spiClk,
    input  logic        i_spiMosi,
    input  logic        i_spiCsTx_n,
    input  logic        i_spiCsLo1_n,
    input  logic        i_spiCe,
    input  logic        i_uart,
    input  logic [47:0] i_iTx,
    input  logic [47:0] i_qTx,
    input  logic [47:0] i_iRx,
    input  logic [47:0] i_qRx,
    output logic        o_calSeen,
    output int          o_wordCount,
    output int          o_frameCount
);

    localparam int PointBytes = 3 + 4 * 4;   // Markers, then four 32-bit samples
    localparam int FrameBytes = 2 * `FRAME_MARK_COUNT + NumPoints * PointBytes;

    logic [47:0] expVal [4][NumPoints];
    int          phase    = 0;   // 0 TX, 1 LO1, 2 calibration
    int          stepIdx  = 0;
    int          curStep  = 0;
    logic        holding  = 1'b0;
    logic        frameActive = 1'b0;
    logic        armed    = 1'b0;

    int errIdle    = 0;
    int errCe      = 0;
    int errWord    = 0;
    int errEdges   = 0;
    int errFrame   = 0;
    int errData    = 0;
    int errOrder   = 0;
    int errOverlap = 0;

    task automatic reportValue(input string name, input logic [47:0] got,
                               input logic [47:0] exp);
        $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
    endtask

    function automatic logic [7:0] expectedByte(input int pos);
        int rel;
        int r;
        int comp;
        int sub;
        rel = pos - `FRAME_MARK_COUNT;
        if (rel < 0) return `FRAME_HEADER_BYTE;
        if (rel >= NumPoints * PointBytes) return `FRAME_STOP_BYTE;
        r = rel % PointBytes;
        if (r < 2) return `FRAME_MARKER_A;
        if (r == 2) return `FRAME_MARKER_B;
        comp = (r - 3) / 4;
        sub  = (r - 3) % 4;
        return 8'(expVal[comp][rel / PointBytes] >> (40 - 8 * sub));   // Bits 47:16
    endfunction

    task automatic checkWord(input logic [23:0] word, input int edges,
                             input logic txSel, input logic lo1Sel);
        logic [23:0] expWord;
        logic [15:0] txN;
        int          sweepsDone;
        txN = 16'(`LMX_TX_N_BASE + stepIdx * `LMX_N_STEP);
        sweepsDone = o_wordCount / (3 * NumPoints);
        case (phase)
            0:       expWord = {`LMX_TX_N_ADDR, txN};
            1:       expWord = {`LMX_LO1_N_ADDR, 16'(txN + `LMX_IF_N_OFFSET)};
            default: expWord = `LMX_VCO_CAL_WORD;
        endcase
        edgeCount: assert (edges == `LMX_WORD_BITS) else begin
            reportValue("SCLK rising edges", 48'(edges), 48'(`LMX_WORD_BITS));
            errEdges++;
        end
        csRoute: assert (txSel == (phase != 1) && lo1Sel == (phase != 0)) else begin
            reportValue("chip selects {tx,lo1}", 48'({txSel, lo1Sel}),
                        48'({phase != 1, phase != 0}));
            errWord++;
        end
        wordValue: assert (word == expWord) else begin
            reportValue("SPI word", 48'(word), 48'(expWord));
            errWord++;
        end
        if (phase == 0 && stepIdx == 0) begin   // Each sweep follows the previous frame
            restartAfterFrame: assert (o_frameCount == sweepsDone) else begin
                reportValue("frames sent before sweep start", 48'(o_frameCount),
                            48'(sweepsDone));
                errOrder++;
            end
        end
        o_wordCount++;
        if (phase == 2) begin
            o_calSeen = 1'b1;   // Testbench loads new accumulators
            curStep   = stepIdx;
            holding   = 1'b1;
            stepIdx   = (stepIdx + 1) % NumPoints;
            phase     = 0;
        end else begin
            phase++;
        end
    endtask

    //////////////////////////////////////////////////
    // SPI decoder
    //////////////////////////////////////////////////
    initial begin : spiDecode
        logic [23:0] word;
        int          edges;
        logic        csNow;
        logic        csPrev;
        logic        sclkPrev;
        logic        txSel;
        logic        lo1Sel;
        word        = '0;
        edges       = 0;
        csPrev      = 1'b0;
        sclkPrev    = 1'b0;
        txSel       = 1'b0;
        lo1Sel      = 1'b0;
        o_calSeen   = 1'b0;
        o_wordCount = 0;
        forever begin
            @(posedge i_clk);
            o_calSeen = 1'b0;
            if (holding) begin   // Inputs held for the whole step
                expVal[0][curStep] = i_iTx;
                expVal[1][curStep] = i_qTx;
                expVal[2][curStep] = i_iRx;
                expVal[3][curStep] = i_qRx;
            end
            csNow = !i_spiCsTx_n || !i_spiCsLo1_n;
            if (csNow && !csPrev) begin
                word   = '0;
                edges  = 0;
                txSel  = !i_spiCsTx_n;
                lo1Sel = !i_spiCsLo1_n;
            end else if (csNow && i_spiClk && !sclkPrev) begin
                word = {word[22:0], i_spiMosi};   // Sampled on rising SCLK
                edges++;
            end
            if (!csNow && csPrev) begin
                checkWord(word, edges, txSel, lo1Sel);
            end
            csPrev   = csNow;
            sclkPrev = i_spiClk;
        end
    end

    //////////////////////////////////////////////////
    // UART decoder
    //////////////////////////////////////////////////
    initial begin : uartDecode
        logic [7:0] rxByte;
        logic [7:0] expByte;
        int         pos;
        int         rel;
        rxByte       = '0;
        pos          = 0;
        o_frameCount = 0;
        forever begin
            @(posedge i_clk);
            if (i_resetN && !i_uart) begin
                if (pos == 0) frameActive = 1'b1;
                repeat (`UART_CLKS_PER_BIT / 2) @(posedge i_clk);   // Middle of start bit
                for (int b = 0; b < 8; b++) begin
                    repeat (`UART_CLKS_PER_BIT) @(posedge i_clk);
                    rxByte[b] = i_uart;
                end
                repeat (`UART_CLKS_PER_BIT) @(posedge i_clk);
                stopBit: assert (i_uart) else begin
                    $display("UART stop bit missing on frame byte %0d", pos);
                    errFrame++;
                end
                expByte = expectedByte(pos);
                rel     = pos - `FRAME_MARK_COUNT;
                if (rel >= 0 && rel < NumPoints * PointBytes && rel % PointBytes >= 3) begin
                    dataByte: assert (rxByte == expByte) else begin
                        reportValue($sformatf("frame data byte %0d", pos), 48'(rxByte),
                                    48'(expByte));
                        errData++;
                    end
                end else begin
                    markByte: assert (rxByte == expByte) else begin
                        reportValue($sformatf("frame mark byte %0d", pos), 48'(rxByte),
                                    48'(expByte));
                        errFrame++;
                    end
                end
                pos++;
                if (pos == FrameBytes) begin
                    pos         = 0;
                    frameActive = 1'b0;
                    o_frameCount++;
                end
            end
        end
    end

    initial begin
        @(posedge i_clk);
        armed = 1'b1;   // Registers hold reset values from here on
    end

    idleInReset: assert property (@(posedge i_clk) armed && !i_resetN |->
        i_spiCsTx_n && i_spiCsLo1_n && !i_spiClk && !i_spiCe && i_uart)
        else begin
            $display("Output lines not idle while reset is held at %0t ns", $time);
            errIdle++;
        end

    ceAfterReset: assert property (@(posedge i_clk) $rose(i_resetN) |=> i_spiCe)
        else begin
            $display("CE did not go high in the first cycle after reset release");
            errCe++;
        end

    quietDuringFrame: assert property (@(posedge i_clk) frameActive |->
        i_spiCsTx_n && i_spiCsLo1_n)
        else begin
            $display("SPI chip select went low during a UART frame at %0t ns", $time);
            errOverlap++;
        end

endmodule

/* test/tbRadarTop.sv */
`timescale 1ns/1ps
`include "radarDefines.svh"

module tbRadarTop import radarPkg::*; ();

    localparam int NumPoints   = 4;
    localparam int DwellCycles = 200;
    localparam int FrameBytes  = 2 * `FRAME_MARK_COUNT + NumPoints * 19;

    // Run length in cycles, two sweeps and two frames
    localparam longint WordCycles  = 2 * `SPI_CLKS_PER_HALF_BIT * `LMX_WORD_BITS
                                     + `SPI_CS_INACTIVE_CLKS + 4;
    localparam longint SweepCycles = NumPoints * (3 * WordCycles + DwellCycles + 4);
    localparam longint FrameCycles = (FrameBytes + 1) * 10 * `UART_CLKS_PER_BIT;
    localparam longint TimeoutNs   = 10 * (16 + 2 * (SweepCycles + FrameCycles)) * 3 / 2;

    logic      CLK100MHZ;
    logic      reset_reg;
    iqSample_t iTxAccum;
    iqSample_t qTxAccum;
    iqSample_t iRxAccum;
    iqSample_t qRxAccum;
    logic      spiClk;
    logic      spiMosi;
    logic      spiCsTx_n;
    logic      spiCsLo1_n;
    logic      spiCe;
    logic      uartLine;
    logic      calSeen;
    int        wordCount;
    int        frameCount;
    int        passCnt;
    int        failCnt;

    always #5 CLK100MHZ = ~CLK100MHZ;

    radarTop #(.NumPoints(NumPoints), .DwellCycles(DwellCycles)) dut0 (
        .CLK100MHZ    (CLK100MHZ),
        .reset_reg    (reset_reg),
        .i_iTxAccum   (iTxAccum),
        .i_qTxAccum   (qTxAccum),
        .i_iRxAccum   (iRxAccum),
        .i_qRxAccum   (qRxAccum),
        .o_spiClk     (spiClk),
        .o_spiMosi    (spiMosi),
        .o_spiCsTx_n  (spiCsTx_n),
        .o_spiCsLo1_n (spiCsLo1_n),
        .o_spiCe      (spiCe),
        .o_uartTx     (uartLine)
    );

    tbBusMonitor #(.NumPoints(NumPoints)) monitor0 (
        .i_clk        (CLK100MHZ),
        .i_resetN     (reset_reg),
        .i_spiClk     (spiClk),
        .i_spiMosi    (spiMosi),
        .i_spiCsTx_n  (spiCsTx_n),
        .i_spiCsLo1_n (spiCsLo1_n),
        .i_spiCe      (spiCe),
        .i_uart       (uartLine),
        .i_iTx        (iTxAccum),
        .i_qTx        (qTxAccum),
        .i_iRx        (iRxAccum),
        .i_qRx        (qRxAccum),
        .o_calSeen    (calSeen),
        .o_wordCount  (wordCount),
        .o_frameCount (frameCount)
    );

    task automatic reportTest(input int num, input string title, input int errs);
        if (errs == 0) begin
            $display("test %0d %s: ok", num, title);
            passCnt++;
        end else begin
            $display("test %0d %s: %0d errors", num, title, errs);
            failCnt++;
        end
    endtask

    //////////////////////////////////////////////////
    // Accumulator stimulus
    //////////////////////////////////////////////////
    initial begin
        iTxAccum = '0;
        qTxAccum = '0;
        iRxAccum = '0;
        qRxAccum = '0;
        void'($urandom(27851));
        forever begin
            @(negedge CLK100MHZ);
            if (calSeen) begin   // New values for the coming dwell
                iTxAccum = {16'($urandom()), $urandom()};
                qTxAccum = {16'($urandom()), $urandom()};
                iRxAccum = {16'($urandom()), $urandom()};
                qRxAccum = {16'($urandom()), $urandom()};
            end
        end
    end

    initial begin
        CLK100MHZ = 1'b0;
        reset_reg = 1'b0;
        passCnt   = 0;
        failCnt   = 0;
        repeat (16) @(posedge CLK100MHZ);
        @(negedge CLK100MHZ);
        reset_reg = 1'b1;
        repeat (4) @(negedge CLK100MHZ);
        reportTest(1, "reset state and CE", monitor0.errIdle + monitor0.errCe);
        wait (wordCount >= 6 * NumPoints);   // Both sweeps written
        reportTest(2, "SPI word order and values", monitor0.errWord);
        reportTest(3, "SCLK edges per word", monitor0.errEdges);
        wait (frameCount >= 2);
        @(negedge CLK100MHZ);
        reportTest(4, "frame header, markers and stop", monitor0.errFrame);
        reportTest(5, "frame data bytes", monitor0.errData);
        reportTest(6, "sweep restart and frame overlap",
                   monitor0.errOrder + monitor0.errOverlap);
        $display("%0d tests ok, %0d tests failed", passCnt, failCnt);
        if (failCnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(TimeoutNs);
        $display("Watchdog expired before both frames were received");
        $display("** FAIL **");
        $finish;
    end

endmodule

/* all.f */
+incdir+include
hdl/radarPkg.sv
hdl/spiWordIf.sv
hdl/lmxSpiWriter.sv
hdl/sweepSequencer.sv
hdl/iqResultStore.sv
hdl/uartFrameBuilder.sv
hdl/uartTx.sv
hdl/radarTop.sv
test/tbBusMonitor.sv
test/tbRadarTop.sv

/* run.sh */
#!/bin/sh
# Compile and run the radar testbench with Verilator

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tbRadarTop \
    -f all.f -o simRadar
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/simRadar > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx '\*\* PASS \*\*' "$LOG"; then
    exit 0
fi
exit 1
